// File: fetch_top.f
verilog/fetch_pkg.sv
verilog/axi_pkg.sv
verilog/fetch_req_if.sv
verilog/refill_if.sv
verilog/icache_refill.sv
verilog/icache.sv
verilog/ifu.sv
verilog/fetch_top.sv
verif/clock_gen.sv
verif/tb_fetch_top.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the fetch path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_fetch_top \
  -f fetch_top.f -o sim_fetch_top

./obj_dir/sim_fetch_top > sim.log 2>&1
cat sim.log

if grep -q "test failed" sim.log; then
  echo "simulation reported errors, see sim.log"
  exit 1
fi
grep -q "test passed" sim.log

// File: verif/clock_gen.sv
//**************************************************************************
// testbench clock and reset
//**************************************************************************

`timescale 1ns/1ps

module clock_gen #(
  parameter int HALF_PERIOD  = 10,
  parameter int RESET_CYCLES = 16
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(HALF_PERIOD) clock = ~clock;
  end

  // release lines up with the other inputs, just after an edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    #2 reset = 1'b0;
  end

endmodule

// File: verif/tb_fetch_top.sv
//**************************************************************************
// fetch path testbench
//**************************************************************************

`timescale 1ns/1ps

module tb_fetch_top;

  localparam int SET_COUNT      = fetch_pkg::DEFAULT_SET_COUNT;
  localparam int LINE_WORDS     = fetch_pkg::DEFAULT_LINE_WORDS;
  localparam int LINE_BYTES     = LINE_WORDS * 4;
  // 400 fetches over all tests at no more than 60 cycles each
  localparam int TIMEOUT_CYCLES = 400 * 60;

  typedef logic [$clog2(SET_COUNT)-1:0] set_t;

  logic                clock, reset;
  logic                in_valid, in_ready, out_valid, out_ready, fencei, ctrl_valid;
  logic                arvalid, arready, rvalid, rready, rlast;
  fetch_pkg::addr_t    pc_in, pc_out, araddr, cur_pc, held_pc, burst_addr;
  fetch_pkg::inst_t    inst, rdata, held_inst;
  axi_pkg::axi_len_t   arlen;
  axi_pkg::axi_size_t  arsize;
  axi_pkg::axi_burst_t arburst;

  // pipeline side and memory side draw from separate streams
  int seed, bus_seed, stall_pct;
  int pass_count, fail_count, shortfalls, hits, refetches;
  int cycles, accept_cycle, bursts, beat, elapsed;
  // reference cache holds one line address per set
  logic [SET_COUNT-1:0] model_valid, fenced;
  fetch_pkg::addr_t     model_line [SET_COUNT];
  set_t                 acc_set;
  logic                 busy, answered, expect_hit, stalled, ar_fire, r_fire, burst_on;

  clock_gen #(.HALF_PERIOD(10), .RESET_CYCLES(16)) u_clock_gen (.clock, .reset);

  fetch_top UUT (
    .clock, .reset, .pc_in, .in_valid, .in_ready, .out_valid, .out_ready, .inst, .pc_out,
    .fencei, .ctrl_valid,
    .io_master_arvalid(arvalid), .io_master_arready(arready), .io_master_araddr(araddr),
    .io_master_arlen(arlen), .io_master_arsize(arsize), .io_master_arburst(arburst),
    .io_master_rvalid(rvalid), .io_master_rready(rready), .io_master_rdata(rdata),
    .io_master_rlast(rlast)
  );

  // memory word is a fixed mix of its byte address
  function automatic fetch_pkg::inst_t mem_word(input fetch_pkg::addr_t addr);
    return (addr * 32'h9e3779b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5bd1e995;
  endfunction

  function automatic fetch_pkg::addr_t line_of(input fetch_pkg::addr_t addr);
    return addr & ~fetch_pkg::addr_t'(LINE_BYTES - 1);
  endfunction

  // line number modulo set count
  function automatic set_t set_of(input fetch_pkg::addr_t addr);
    return set_t'(addr / LINE_BYTES);
  endfunction

  task automatic inst_equal(input string what, input fetch_pkg::inst_t got,
                            input fetch_pkg::inst_t exp);
    if (got !== exp) begin
      fail_count++;
      $display("[FAIL] %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end else begin
      pass_count++;
    end
  endtask

  task automatic addr_equal(input string what, input fetch_pkg::addr_t got,
                            input fetch_pkg::addr_t exp);
    if (got !== exp) begin
      fail_count++;
      $display("[FAIL] %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end else begin
      pass_count++;
    end
  endtask

  // expects one incrementing burst of four-byte beats per line
  task automatic burst_fields_ok(input axi_pkg::axi_len_t len, input axi_pkg::axi_size_t size,
                                 input axi_pkg::axi_burst_t kind);
    if (len !== axi_pkg::axi_len_t'(LINE_WORDS - 1) || size !== axi_pkg::AXI_SIZE_4B ||
        kind !== axi_pkg::AXI_BURST_INCR) begin
      fail_count++;
      $display("[FAIL] %0t ns: burst len %0d size %0d kind %0d, expected len %0d size 2 kind 1",
               $time, len, size, kind, LINE_WORDS - 1);
    end else begin
      pass_count++;
    end
  endtask

  task automatic count_equal(input string what, input int got, input int exp);
    if (got != exp) begin
      fail_count++;
      $display("[FAIL] %0t ns: %s got %0d, expected %0d", $time, what, got, exp);
    end else begin
      pass_count++;
    end
  endtask

  task automatic protocol_error(input string msg);
    fail_count++;
    $display("%0t ns: %s", $time, msg);
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #2;
  endtask

  // one fetch at a time with fence.i only while the unit is idle
  task automatic run_test(input string name, input int count, input fetch_pkg::addr_t mask,
                          input int fence_pct, input int stall);
    int hits0, fails0, refetch0;
    hits0 = hits;
    fails0 = fail_count + shortfalls;
    refetch0 = refetches;
    stall_pct = stall;
    for (int n = 0; n < count; n++) begin
      repeat ($unsigned($random(seed)) % 3) next_cycle();
      if ($unsigned($random(seed)) % 100 < fence_pct && in_ready) begin
        fencei = 1'b1;
        ctrl_valid = 1'b1;
        next_cycle();
        fencei = 1'b0;
        ctrl_valid = 1'b0;
      end
      pc_in = 32'h8000_0000 | (fetch_pkg::addr_t'($random(seed)) & mask);
      in_valid = 1'b1;
      do @(negedge clock); while (!in_ready);
      next_cycle();
      in_valid = 1'b0;
      do @(negedge clock); while (!(out_valid && out_ready));
      next_cycle();
    end
    if (fence_pct > 0 && refetches == refetch0) begin
      shortfalls++;
      $display("%s: no cached line was fetched again after a fence.i", name);
    end
    $display("%s: %0d fetches, %0d hits, %0d refetches after fence.i, %0d errors", name, count,
             hits - hits0, refetches - refetch0, fail_count + shortfalls - fails0);
  endtask

  // memory model with random arready and rvalid delays
  initial begin
    bus_seed = 32'h29cfdc52 ^ 32'h6d2b79f5;
    {arready, rvalid, rlast, out_ready, burst_on} = '0;
    rdata = '0;
    beat = 0;
    @(negedge reset);
    forever begin
      next_cycle();
      if (ar_fire) begin
        burst_on = 1'b1;
        burst_addr = araddr;
        beat = 0;
      end
      if (r_fire) beat++;
      if (beat == LINE_WORDS) burst_on = 1'b0;
      arready = !burst_on && ($unsigned($random(bus_seed)) % 4 != 0);
      // a beat on offer stays until taken
      if (!(rvalid && !r_fire)) begin
        rvalid = burst_on && ($unsigned($random(bus_seed)) % 3 != 0);
        rdata = mem_word(burst_addr + fetch_pkg::addr_t'(4 * beat));
        rlast = (beat == LINE_WORDS - 1);
      end
      out_ready = ($unsigned($random(bus_seed)) % 100 >= stall_pct);
    end
  end

  // monitor samples at the falling edge where all signals are settled
  initial begin
    {cycles, pass_count, fail_count, hits, refetches, bursts} = '0;
    {model_valid, fenced} = '0;
    {busy, answered, stalled, ar_fire, r_fire} = '0;
    forever begin
      @(negedge clock);
      if (!reset) begin
        cycles++;
        ar_fire = arvalid && arready;
        r_fire = rvalid && rready;
        if (stalled) begin
          if (!out_valid || in_ready) protocol_error("output released while out_ready was low");
          inst_equal("held inst", inst, held_inst);
          addr_equal("held pc_out", pc_out, held_pc);
        end
        if (out_valid && !busy) protocol_error("out_valid with no fetch in flight");
        if (rready !== burst_on) protocol_error("rready does not follow the read burst");
        if (fencei && ctrl_valid) begin
          fenced = fenced | model_valid;
          model_valid = '0;
        end
        if (in_valid && in_ready) begin
          acc_set = set_of(pc_in);
          expect_hit = model_valid[acc_set] && model_line[acc_set] == line_of(pc_in);
          if (!expect_hit && fenced[acc_set] && model_line[acc_set] == line_of(pc_in))
            refetches++;
          if (expect_hit) hits++;
          model_valid[acc_set] = 1'b1;
          fenced[acc_set] = 1'b0;
          model_line[acc_set] = line_of(pc_in);
          cur_pc = pc_in;
          accept_cycle = cycles;
          bursts = 0;
          busy = 1'b1;
          answered = 1'b0;
        end
        if (arvalid && busy && expect_hit && !answered)
          protocol_error("arvalid raised for a fetch predicted to hit");
        if (ar_fire) begin
          bursts++;
          if (!busy || answered) protocol_error("read burst with no miss waiting for it");
          addr_equal("araddr", araddr, line_of(cur_pc));
          burst_fields_ok(arlen, arsize, arburst);
        end
        if (out_valid && busy && !answered) begin
          answered = 1'b1;
          inst_equal("inst", inst, mem_word(cur_pc));
          addr_equal("pc_out", pc_out, cur_pc);
          count_equal("bursts for one fetch", bursts, expect_hit ? 0 : 1);
          if (expect_hit) count_equal("hit latency", cycles - accept_cycle, 2);
        end
        if (out_valid && out_ready) busy = 1'b0;
        stalled = out_valid && !out_ready;
        held_inst = inst;
        held_pc = pc_out;
      end
    end
  end

  initial begin
    elapsed = 0;
    while (elapsed < TIMEOUT_CYCLES) begin
      @(posedge clock);
      if (!reset) elapsed++;
    end
    $display("run timed out after %0d cycles", elapsed);
    $display("test failed");
    $finish;
  end

  initial begin
    seed = 32'h29cfdc52;
    pc_in = '0;
    {in_valid, fencei, ctrl_valid} = '0;
    stall_pct = 0;
    shortfalls = 0;
    @(negedge reset);
    next_cycle();
    // 1 KiB window is four times the cache and 256 bytes just fits it
    run_test("random fetch", 160, 32'h3fc, 0, 30);
    run_test("fence.i refetch", 120, 32'h0fc, 12, 20);
    run_test("back-pressure", 120, 32'h3fc, 3, 75);
    repeat (4) next_cycle();
    $display("checks passed %0d, failed %0d", pass_count, fail_count + shortfalls);
    if (fail_count + shortfalls == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: verilog/axi_pkg.sv
//**************************************************************************
// axi4 read channel fields
//**************************************************************************

package axi_pkg;

  // beats per burst minus one
  typedef logic [7:0] axi_len_t;
  // log2 of bytes per beat
  typedef logic [2:0] axi_size_t;
  typedef logic [1:0] axi_burst_t;

  // encodings from the axi4 spec
  parameter axi_burst_t AXI_BURST_INCR = 2'b01;
  parameter axi_size_t  AXI_SIZE_4B    = 3'b010;

endpackage

// File: verilog/fetch_pkg.sv
//**************************************************************************
// instruction fetch types
//**************************************************************************

package fetch_pkg;

  // byte address of one instruction
  typedef logic [31:0] addr_t;

  // one raw rv32 instruction word
  typedef logic [31:0] inst_t;

  // cache geometry defaults
  // top level may override both, powers of two only
  parameter int DEFAULT_SET_COUNT = 16;

  // words per line, also the burst length
  parameter int DEFAULT_LINE_WORDS = 4;

endpackage

// File: verilog/fetch_req_if.sv
//**************************************************************************
// fetch unit to icache request bus
//**************************************************************************

`timescale 1ns/1ps

interface fetch_req_if;

  // request side, pc held until inst_valid
  logic             require;
  fetch_pkg::addr_t pc;
  // fence.i from the control path
  logic             fencei;
  logic             ctrl_valid;

  // answer side, inst_valid is a single-cycle pulse
  logic             inst_valid;
  fetch_pkg::inst_t inst;

  modport fetch (output require, pc, fencei, ctrl_valid, input inst_valid, inst);

  modport cache (input require, pc, fencei, ctrl_valid, output inst_valid, inst);

endinterface

// File: verilog/fetch_top.sv
//**************************************************************************
// fetch path top level
//**************************************************************************

`timescale 1ns/1ps

module fetch_top #(
  parameter int SET_COUNT  = fetch_pkg::DEFAULT_SET_COUNT,
  parameter int LINE_WORDS = fetch_pkg::DEFAULT_LINE_WORDS
) (
  input  logic                clock,
  input  logic                reset,
  input  fetch_pkg::addr_t    pc_in,
  input  logic                in_valid,
  output logic                in_ready,
  output logic                out_valid,
  input  logic                out_ready,
  output fetch_pkg::inst_t    inst,
  output fetch_pkg::addr_t    pc_out,
  input  logic                fencei,
  input  logic                ctrl_valid,
  output logic                io_master_arvalid,
  input  logic                io_master_arready,
  output fetch_pkg::addr_t    io_master_araddr,
  output axi_pkg::axi_len_t   io_master_arlen,
  output axi_pkg::axi_size_t  io_master_arsize,
  output axi_pkg::axi_burst_t io_master_arburst,
  input  logic                io_master_rvalid,
  output logic                io_master_rready,
  input  fetch_pkg::inst_t    io_master_rdata,
  input  logic                io_master_rlast
);

  fetch_req_if fetch_bus ();
  refill_if    refill_bus ();

  // pipeline side
  ifu u_ifu (
    .clock, .reset, .pc_in, .in_valid, .in_ready, .out_valid, .out_ready,
    .inst, .pc_out, .fencei, .ctrl_valid, .fetch(fetch_bus.fetch)
  );

  icache #(.SET_COUNT(SET_COUNT), .LINE_WORDS(LINE_WORDS)) u_icache (
    .clock, .reset, .fetch(fetch_bus.cache), .refill(refill_bus.cache)
  );

  // memory side, read channels only
  icache_refill #(.LINE_WORDS(LINE_WORDS)) u_refill (
    .clock, .reset, .refill(refill_bus.refill),
    .arvalid(io_master_arvalid), .arready(io_master_arready), .araddr(io_master_araddr),
    .arlen(io_master_arlen), .arsize(io_master_arsize), .arburst(io_master_arburst),
    .rvalid(io_master_rvalid), .rready(io_master_rready), .rdata(io_master_rdata),
    .rlast(io_master_rlast)
  );

endmodule

// File: verilog/icache.sv
//**************************************************************************
// direct-mapped instruction cache
//**************************************************************************

`timescale 1ns/1ps

module icache #(
  parameter int SET_COUNT  = fetch_pkg::DEFAULT_SET_COUNT,
  parameter int LINE_WORDS = fetch_pkg::DEFAULT_LINE_WORDS
) (
  input logic        clock,
  input logic        reset,
  fetch_req_if.cache fetch,
  refill_if.cache    refill
);

  // address split: tag | index | word | byte
  localparam int WORD_W   = $clog2(LINE_WORDS);
  localparam int INDEX_W  = $clog2(SET_COUNT);
  localparam int LINE_LSB = WORD_W + 2;
  localparam int TAG_W    = 32 - INDEX_W - LINE_LSB;

  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [WORD_W-1:0]  word_t;
  typedef enum logic [1:0] {S_IDLE, S_LOOKUP, S_REFILL, S_RESPOND} state_t;

  state_t               state;
  tag_t                 tag_mem [SET_COUNT];
  fetch_pkg::inst_t     data_mem [SET_COUNT][LINE_WORDS];
  logic [SET_COUNT-1:0] line_valid;
  word_t                fill_word;
  logic                 fence_pending;
  tag_t                 pc_tag;
  index_t               pc_index;
  word_t                pc_word;
  logic                 hit;
  logic                 fence_req;
  logic                 fence_apply;

  // pc is held by the fetch unit for the whole access
  assign pc_tag   = fetch.pc[31 -: TAG_W];
  assign pc_index = fetch.pc[LINE_LSB +: INDEX_W];
  assign pc_word  = fetch.pc[2 +: WORD_W];

  assign hit = line_valid[pc_index] && (tag_mem[pc_index] == pc_tag);

  // same read port for hits and for the freshly filled line
  assign fetch.inst       = data_mem[pc_index][pc_word];
  assign fetch.inst_valid = (state == S_LOOKUP && hit) || (state == S_RESPOND);

  assign refill.req  = (state == S_LOOKUP) && !hit;
  assign refill.addr = {fetch.pc[31:LINE_LSB], {LINE_LSB{1'b0}}};

  // fence.i waits for a running refill to finish
  assign fence_req   = fetch.fencei && fetch.ctrl_valid;
  assign fence_apply = (state != S_REFILL) ? fence_req
                                           : refill.done && (fence_req || fence_pending);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE:    if (fetch.require) state <= S_LOOKUP;
        S_LOOKUP:  state <= hit ? S_IDLE : S_REFILL;
        S_REFILL:  if (refill.done) state <= S_RESPOND;
        S_RESPOND: state <= S_IDLE;
        default:   state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) fence_pending <= 1'b0;
    else if (fence_apply) fence_pending <= 1'b0;
    else if (fence_req) fence_pending <= 1'b1;
  end

  // beat position inside the line
  always_ff @(posedge clock) begin
    if (reset) fill_word <= '0;
    else if (refill.req) fill_word <= '0;
    else if (refill.beat_valid) fill_word <= fill_word + 1'b1;
  end

  // valid set on the last beat, a late fence clears it again on done
  always_ff @(posedge clock) begin
    if (reset) line_valid <= '0;
    else if (fence_apply) line_valid <= '0;
    else if (refill.beat_valid && refill.beat_last) line_valid[pc_index] <= 1'b1;
  end

  always_ff @(posedge clock) begin
    if (refill.beat_valid) data_mem[pc_index][fill_word] <= refill.beat_data;
    if (refill.beat_valid && refill.beat_last) tag_mem[pc_index] <= pc_tag;
  end

  // one refill at a time, next request only after done
  single_refill: assert property (@(posedge clock) disable iff (reset)
    refill.req |=> !refill.req until refill.done);

endmodule

// File: verilog/icache_refill.sv
//**************************************************************************
// icache refill burst master
//**************************************************************************

`timescale 1ns/1ps

module icache_refill #(
  parameter int LINE_WORDS = fetch_pkg::DEFAULT_LINE_WORDS
) (
  input  logic                clock,
  input  logic                reset,
  refill_if.refill            refill,
  output logic                arvalid,
  input  logic                arready,
  output fetch_pkg::addr_t    araddr,
  output axi_pkg::axi_len_t   arlen,
  output axi_pkg::axi_size_t  arsize,
  output axi_pkg::axi_burst_t arburst,
  input  logic                rvalid,
  output logic                rready,
  input  fetch_pkg::inst_t    rdata,
  input  logic                rlast
);

  typedef enum logic [1:0] {S_IDLE, S_ADDR, S_DATA} state_t;

  state_t state;

  // burst shape never changes, one full line of words
  assign arlen   = axi_pkg::axi_len_t'(LINE_WORDS - 1);
  assign arsize  = axi_pkg::AXI_SIZE_4B;
  assign arburst = axi_pkg::AXI_BURST_INCR;

  assign arvalid = (state == S_ADDR);
  // cache always has room for the whole line
  assign rready  = (state == S_DATA);

  // beats go straight through to the cache
  assign refill.beat_valid = rvalid && rready;
  assign refill.beat_data  = rdata;
  assign refill.beat_last  = rlast;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE:  if (refill.req) state <= S_ADDR;
        S_ADDR:  if (arready) state <= S_DATA;
        S_DATA:  if (rvalid && rlast) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  // address captured once, held through the ar handshake
  always_ff @(posedge clock) begin
    if (state == S_IDLE && refill.req) araddr <= refill.addr;
  end

  // done trails the last beat by one cycle
  always_ff @(posedge clock) begin
    if (reset) refill.done <= 1'b0;
    else refill.done <= (state == S_DATA) && rvalid && rlast;
  end

  // ar payload must not move before the slave takes it
  ar_hold: assert property (@(posedge clock) disable iff (reset)
    arvalid && !arready |=> $stable(araddr) && arvalid);

endmodule

// File: verilog/ifu.sv
//**************************************************************************
// instruction fetch unit
//**************************************************************************

`timescale 1ns/1ps

module ifu (
  input  logic             clock,
  input  logic             reset,
  input  fetch_pkg::addr_t pc_in,
  input  logic             in_valid,
  output logic             in_ready,
  output logic             out_valid,
  input  logic             out_ready,
  output fetch_pkg::inst_t inst,
  output fetch_pkg::addr_t pc_out,
  input  logic             fencei,
  input  logic             ctrl_valid,
  fetch_req_if.fetch       fetch
);

  fetch_pkg::addr_t pc;

  // single pulse, in_ready drops right after
  assign fetch.require    = in_valid && in_ready;
  assign fetch.pc         = pc;
  // cache decides when a fence takes effect
  assign fetch.fencei     = fencei;
  assign fetch.ctrl_valid = ctrl_valid;
  assign pc_out           = pc;

  // closed from acceptance until decode takes the inst
  always_ff @(posedge clock) begin
    if (reset) in_ready <= 1'b1;
    else if (in_valid && in_ready) in_ready <= 1'b0;
    else if (!in_ready && out_valid && out_ready) in_ready <= 1'b1;
  end

  always_ff @(posedge clock) begin
    if (reset) out_valid <= 1'b0;
    else if (!in_ready && fetch.inst_valid) out_valid <= 1'b1;
    else if (out_valid && out_ready) out_valid <= 1'b0;
  end

  always_ff @(posedge clock) begin
    if (in_valid && in_ready) pc <= pc_in;
  end

  // one answer per fetch, so inst holds under back-pressure
  always_ff @(posedge clock) begin
    if (fetch.inst_valid) inst <= fetch.inst;
  end

  no_overlap: assert property (@(posedge clock) disable iff (reset) !(in_ready && out_valid));

endmodule

// File: verilog/refill_if.sv
//**************************************************************************
// icache line refill bus
//**************************************************************************

`timescale 1ns/1ps

interface refill_if;

  // line request, addr is line aligned
  logic             req;
  fetch_pkg::addr_t addr;

  // one beat per accepted r handshake
  logic             beat_valid;
  fetch_pkg::inst_t beat_data;
  logic             beat_last;
  // cycle after the last beat
  logic             done;

  modport cache (output req, addr, input beat_valid, beat_data, beat_last, done);

  modport refill (input req, addr, output beat_valid, beat_data, beat_last, done);

endinterface
